//--- src/arya_pkg.sv
package arya_pkg;

    //////////////////////////////////////////////////////////////////////
    // instruction format
    //////////////////////////////////////////////////////////////////////

    localparam int inst_width  = 32;
    localparam int shamt_width = 5;

    // field positions in the instruction word
    localparam int op_msb    = 31;
    localparam int op_lsb    = 26;
    localparam int rs_msb    = 25;
    localparam int rs_lsb    = 21;
    localparam int rt_msb    = 20;
    localparam int rt_lsb    = 16;
    localparam int rd_msb    = 15;
    localparam int rd_lsb    = 11;
    localparam int shamt_msb = 10;
    localparam int shamt_lsb = 6;
    // only the low four funct bits select the alu op
    localparam int funct_msb = 3;
    localparam int funct_lsb = 0;
    localparam int imm_msb   = 15;
    localparam int imm_lsb   = 0;

    // major opcodes
    typedef enum logic [5:0] {
        op_rtype = 6'd0,
        op_beq   = 6'd4,
        op_bne   = 6'd5,
        op_addi  = 6'd8,
        op_ori   = 6'd13,
        op_lw    = 6'd35,
        op_sw    = 6'd43,
        op_halt  = 6'd63
    } opcode_t;

    // alu ops, also the funct code of r-type
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_nor = 4'd5,
        alu_slt = 4'd6,
        alu_sll = 4'd7,
        alu_srl = 4'd8
    } alu_op_t;

    // all ones decodes as op_halt
    localparam logic [inst_width-1:0] halt_word = '1;

endpackage

//--- src/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit import arya_pkg::*; #(
    parameter int inst_addr_width = 9,
    parameter int mem_addr_width  = 10,
    parameter int datapath_width  = 64
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       setup_mem,
    input  logic                       verify_mem,
    input  logic                       enable_mem,
    input  logic [mem_addr_width-1:0]  mem_addr,
    input  logic                       halt,
    input  logic                       branch_taken,
    input  logic [inst_addr_width-1:0] branch_target,
    input  logic [datapath_width-1:0]  mem_dout_a,
    output logic [mem_addr_width-1:0]  mem_addr_a,
    output logic                       mem_we_a,
    output logic                       mem_en,
    output logic [inst_width-1:0]      inst,
    output logic [inst_addr_width-1:0] inst_pc
);

    logic                       debug_mem;
    logic [inst_addr_width-1:0] pc;

    // debug port owns port a during setup or verify
    assign debug_mem  = setup_mem | verify_mem;
    assign mem_addr_a = debug_mem ? mem_addr : mem_addr_width'(pc);
    assign mem_we_a   = setup_mem;

    // halted core stops the ram, unless the host still needs it
    assign mem_en = ~halt | enable_mem;

    // decoder sees halt while the host is busy, core stays frozen
    assign inst = debug_mem ? halt_word : mem_dout_a[inst_width-1:0];

    //////////////////////////////////////////////////////////////////////
    // program counter
    //////////////////////////////////////////////////////////////////////

    // pc is the fetch address, inst_pc trails it by the ram latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= '0;
            inst_pc <= '0;
        end else if (!halt) begin
            // branch resolved in mem stage overrides the increment
            pc      <= branch_taken ? branch_target : pc + 1'b1;
            inst_pc <= pc;
        end
    end

endmodule

//--- src/unified_mem.sv
`timescale 1ns/10ps

module unified_mem #(
    parameter int data_width = 64,
    parameter int addr_width = 10
) (
    input  logic                  clk,
    input  logic                  en,
    input  logic [addr_width-1:0] addr_a,
    input  logic [data_width-1:0] din_a,
    input  logic                  we_a,
    output logic [data_width-1:0] dout_a,
    input  logic [addr_width-1:0] addr_b,
    input  logic [data_width-1:0] din_b,
    input  logic                  we_b,
    output logic [data_width-1:0] dout_b
);

    localparam int depth = 1 << addr_width;

    // lower half program, upper half data
    logic [data_width-1:0] mem [0:depth-1];

    // both ports write-first; outputs hold while disabled
    always_ff @(posedge clk) begin
        if (en) begin
            if (we_a) begin
                mem[addr_a] <= din_a;
                dout_a      <= din_a;
            end else begin
                dout_a <= mem[addr_a];
            end
            // port b wins a same-address collision
            if (we_b) begin
                mem[addr_b] <= din_b;
                dout_b      <= din_b;
            end else begin
                dout_b <= mem[addr_b];
            end
        end
    end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder import arya_pkg::*; #(
    parameter int datapath_width     = 64,
    parameter int regfile_addr_width = 5,
    parameter int inst_addr_width    = 9
) (
    input  logic [inst_width-1:0]         inst,
    output logic [regfile_addr_width-1:0] rs_addr,
    output logic [regfile_addr_width-1:0] rt_addr,
    output logic [regfile_addr_width-1:0] wr_addr,
    output logic [datapath_width-1:0]     imm,
    output logic [shamt_width-1:0]        shamt,
    output logic [inst_addr_width-1:0]    branch_offset,
    output alu_op_t                       alu_op,
    output logic                          use_imm,
    output logic                          wr_en,
    output logic                          mem_to_reg,
    output logic                          mem_write,
    output logic                          beq,
    output logic                          bne,
    output logic                          halt
);

    localparam int imm_width = imm_msb - imm_lsb + 1;

    opcode_t opcode;
    logic    imm_zext;

    // field extraction
    assign opcode        = opcode_t'(inst[op_msb:op_lsb]);
    assign rs_addr       = inst[rs_msb:rs_lsb];
    assign rt_addr       = inst[rt_msb:rt_lsb];
    assign shamt         = inst[shamt_msb:shamt_lsb];
    // low bits of imm, pc relative
    assign branch_offset = inst[imm_lsb +: inst_addr_width];

    // immediate forms write rt, r-type writes rd
    assign wr_addr = use_imm ? rt_addr : inst[rd_msb:rd_lsb];

    // ori zero extends, the rest sign extend
    assign imm = imm_zext ?
        {{(datapath_width-imm_width){1'b0}}, inst[imm_msb:imm_lsb]} :
        {{(datapath_width-imm_width){inst[imm_msb]}}, inst[imm_msb:imm_lsb]};

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op     = alu_add;
        use_imm    = 1'b0;
        imm_zext   = 1'b0;
        wr_en      = 1'b0;
        mem_to_reg = 1'b0;
        mem_write  = 1'b0;
        beq        = 1'b0;
        bne        = 1'b0;
        halt       = 1'b0;
        case (opcode)
            op_rtype: begin
                // funct picks the alu op
                alu_op = alu_op_t'(inst[funct_msb:funct_lsb]);
                wr_en  = 1'b1;
            end
            op_addi: begin
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            op_ori: begin
                alu_op   = alu_or;
                use_imm  = 1'b1;
                imm_zext = 1'b1;
                wr_en    = 1'b1;
            end
            op_lw: begin
                use_imm    = 1'b1;
                wr_en      = 1'b1;
                mem_to_reg = 1'b1;
            end
            op_sw: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            // compare by subtraction, zero flag decides
            op_beq: begin
                alu_op = alu_sub;
                beq    = 1'b1;
            end
            op_bne: begin
                alu_op = alu_sub;
                bne    = 1'b1;
            end
            op_halt: halt = 1'b1;
            // unknown opcodes run as nops
            default: ;
        endcase
    end

endmodule

//--- src/regfile.sv
`timescale 1ns/10ps

module regfile #(
    parameter int datapath_width     = 64,
    parameter int regfile_addr_width = 5
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [regfile_addr_width-1:0] rs_addr,
    input  logic [regfile_addr_width-1:0] rt_addr,
    input  logic                          wr_en,
    input  logic [regfile_addr_width-1:0] wr_addr,
    input  logic [datapath_width-1:0]     wr_data,
    output logic [datapath_width-1:0]     rs_data,
    output logic [datapath_width-1:0]     rt_data
);

    localparam int num_regs = 1 << regfile_addr_width;

    logic [datapath_width-1:0] regs [0:num_regs-1];

    // write at end of writeback, visible to the next decode
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 reads zero whatever was written
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- src/execute_pipe.sv
`timescale 1ns/10ps

module execute_pipe import arya_pkg::*; #(
    parameter int datapath_width     = 64,
    parameter int regfile_addr_width = 5,
    parameter int inst_addr_width    = 9
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          halt,
    input  logic [inst_addr_width-1:0]    inst_pc,
    input  logic [datapath_width-1:0]     rs_data,
    input  logic [datapath_width-1:0]     rt_data,
    input  logic [datapath_width-1:0]     imm,
    input  logic [shamt_width-1:0]        shamt,
    input  logic [inst_addr_width-1:0]    branch_offset,
    input  alu_op_t                       alu_op,
    input  logic                          use_imm,
    input  logic [regfile_addr_width-1:0] wr_addr,
    input  logic                          wr_en,
    input  logic                          mem_to_reg,
    input  logic                          mem_write,
    input  logic                          beq,
    input  logic                          bne,
    input  logic [datapath_width-1:0]     mem_dout_b,
    output logic                          branch_taken,
    output logic [inst_addr_width-1:0]    branch_target,
    output logic [inst_addr_width:0]      mem_addr_b,
    output logic [datapath_width-1:0]     mem_din_b,
    output logic                          mem_we_b,
    output logic                          wb_wr_en,
    output logic [regfile_addr_width-1:0] wb_addr,
    output logic [datapath_width-1:0]     wb_data
);

    // decode/execute
    logic [inst_addr_width-1:0]    de_pc;
    logic [inst_addr_width-1:0]    de_offset;
    logic [datapath_width-1:0]     de_op_a;
    logic [datapath_width-1:0]     de_op_b;
    logic [datapath_width-1:0]     de_store;
    logic [shamt_width-1:0]        de_shamt;
    alu_op_t                       de_alu_op;
    logic [regfile_addr_width-1:0] de_wr_addr;
    logic                          de_mem_to_reg;
    logic                          de_wr_en;
    logic                          de_mem_write;
    logic                          de_beq;
    logic                          de_bne;
    // execute/memory
    logic [datapath_width-1:0]     alu_result;
    logic [datapath_width-1:0]     em_result;
    logic [datapath_width-1:0]     em_store;
    logic [inst_addr_width-1:0]    em_target;
    logic                          em_zero;
    logic [regfile_addr_width-1:0] em_wr_addr;
    logic                          em_mem_to_reg;
    logic                          em_wr_en;
    logic                          em_mem_write;
    logic                          em_beq;
    logic                          em_bne;
    // memory/writeback
    logic [datapath_width-1:0]     mw_result;
    logic [regfile_addr_width-1:0] mw_wr_addr;
    logic                          mw_mem_to_reg;
    logic                          mw_wr_en;

    //////////////////////////////////////////////////////////////////////
    // pipeline registers, all frozen by halt
    //////////////////////////////////////////////////////////////////////

    // control flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_wr_en     <= 1'b0;
            de_mem_write <= 1'b0;
            de_beq       <= 1'b0;
            de_bne       <= 1'b0;
            em_wr_en     <= 1'b0;
            em_mem_write <= 1'b0;
            em_beq       <= 1'b0;
            em_bne       <= 1'b0;
            mw_wr_en     <= 1'b0;
        end else if (!halt) begin
            de_wr_en     <= wr_en;
            de_mem_write <= mem_write;
            de_beq       <= beq;
            de_bne       <= bne;
            em_wr_en     <= de_wr_en;
            em_mem_write <= de_mem_write;
            em_beq       <= de_beq;
            em_bne       <= de_bne;
            mw_wr_en     <= em_wr_en;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (!halt) begin
            de_pc         <= inst_pc;
            de_offset     <= branch_offset;
            de_op_a       <= rs_data;
            // second operand muxed before the register
            de_op_b       <= use_imm ? imm : rt_data;
            de_store      <= rt_data;
            de_shamt      <= shamt;
            de_alu_op     <= alu_op;
            de_wr_addr    <= wr_addr;
            de_mem_to_reg <= mem_to_reg;
            em_result     <= alu_result;
            em_store      <= de_store;
            // target wraps inside program space
            em_target     <= de_pc + de_offset;
            em_zero       <= (alu_result == '0);
            em_wr_addr    <= de_wr_addr;
            em_mem_to_reg <= de_mem_to_reg;
            mw_result     <= em_result;
            mw_wr_addr    <= em_wr_addr;
            mw_mem_to_reg <= em_mem_to_reg;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // alu, shifts act on rs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (de_alu_op)
            alu_add: alu_result = de_op_a + de_op_b;
            alu_sub: alu_result = de_op_a - de_op_b;
            alu_and: alu_result = de_op_a & de_op_b;
            alu_or:  alu_result = de_op_a | de_op_b;
            alu_xor: alu_result = de_op_a ^ de_op_b;
            alu_nor: alu_result = ~(de_op_a | de_op_b);
            alu_slt: alu_result = datapath_width'($signed(de_op_a) < $signed(de_op_b));
            alu_sll: alu_result = de_op_a << de_shamt;
            alu_srl: alu_result = de_op_a >> de_shamt;
            default: alu_result = '0;
        endcase
    end

    // memory stage, branch resolve and data port
    assign branch_taken  = (em_beq & em_zero) | (em_bne & ~em_zero);
    assign branch_target = em_target;
    // data area is the upper half of the ram
    assign mem_addr_b    = {1'b1, em_result[inst_addr_width-1:0]};
    assign mem_din_b     = em_store;
    assign mem_we_b      = em_mem_write & ~halt;

    // writeback, load data arrives one cycle after the address
    assign wb_data  = mw_mem_to_reg ? mem_dout_b : mw_result;
    assign wb_addr  = mw_wr_addr;
    assign wb_wr_en = mw_wr_en & ~halt;

endmodule

//--- src/arya_top.sv
`timescale 1ns/10ps

module arya_top import arya_pkg::*; #(
    parameter int datapath_width     = 64,
    parameter int mem_addr_width     = 10,
    parameter int inst_addr_width    = 9,
    parameter int regfile_addr_width = 5
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      setup_mem,
    input  logic                      verify_mem,
    input  logic                      enable_mem,
    input  logic [mem_addr_width-1:0] mem_addr,
    input  logic [datapath_width-1:0] mem_data_in,
    output logic [datapath_width-1:0] mem_data_out
);

    //////////////////////////////////////////////////////////////////////
    // memory ports
    //////////////////////////////////////////////////////////////////////

    logic [mem_addr_width-1:0]     mem_addr_a;
    logic                          mem_we_a;
    logic                          mem_en;
    logic [mem_addr_width-1:0]     mem_addr_b;
    logic [datapath_width-1:0]     mem_din_b;
    logic                          mem_we_b;
    logic [datapath_width-1:0]     mem_dout_b;

    // fetch and branch
    logic [inst_width-1:0]         inst;
    logic [inst_addr_width-1:0]    inst_pc;
    logic                          halt;
    logic                          branch_taken;
    logic [inst_addr_width-1:0]    branch_target;

    // decode outputs
    logic [regfile_addr_width-1:0] rs_addr;
    logic [regfile_addr_width-1:0] rt_addr;
    logic [regfile_addr_width-1:0] wr_addr;
    logic [datapath_width-1:0]     imm;
    logic [shamt_width-1:0]        shamt;
    logic [inst_addr_width-1:0]    branch_offset;
    alu_op_t                       alu_op;
    logic                          use_imm;
    logic                          wr_en;
    logic                          mem_to_reg;
    logic                          mem_write;
    logic                          beq;
    logic                          bne;

    // register file
    logic [datapath_width-1:0]     rs_data;
    logic [datapath_width-1:0]     rt_data;
    logic                          wb_wr_en;
    logic [regfile_addr_width-1:0] wb_addr;
    logic [datapath_width-1:0]     wb_data;

    //////////////////////////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////////////////////////

    fetch_unit #(
        .inst_addr_width (inst_addr_width),
        .mem_addr_width  (mem_addr_width),
        .datapath_width  (datapath_width)
    ) i_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .setup_mem     (setup_mem),
        .verify_mem    (verify_mem),
        .enable_mem    (enable_mem),
        .mem_addr      (mem_addr),
        .halt          (halt),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .mem_dout_a    (mem_data_out),
        .mem_addr_a    (mem_addr_a),
        .mem_we_a      (mem_we_a),
        .mem_en        (mem_en),
        .inst          (inst),
        .inst_pc       (inst_pc)
    );

    // port a doubles as the debug read port
    unified_mem #(
        .data_width (datapath_width),
        .addr_width (mem_addr_width)
    ) i_mem (
        .clk    (clk),
        .en     (mem_en),
        .addr_a (mem_addr_a),
        .din_a  (mem_data_in),
        .we_a   (mem_we_a),
        .dout_a (mem_data_out),
        .addr_b (mem_addr_b),
        .din_b  (mem_din_b),
        .we_b   (mem_we_b),
        .dout_b (mem_dout_b)
    );

    inst_decoder #(
        .datapath_width     (datapath_width),
        .regfile_addr_width (regfile_addr_width),
        .inst_addr_width    (inst_addr_width)
    ) i_decoder (
        .inst          (inst),
        .rs_addr       (rs_addr),
        .rt_addr       (rt_addr),
        .wr_addr       (wr_addr),
        .imm           (imm),
        .shamt         (shamt),
        .branch_offset (branch_offset),
        .alu_op        (alu_op),
        .use_imm       (use_imm),
        .wr_en         (wr_en),
        .mem_to_reg    (mem_to_reg),
        .mem_write     (mem_write),
        .beq           (beq),
        .bne           (bne),
        .halt          (halt)
    );

    regfile #(
        .datapath_width     (datapath_width),
        .regfile_addr_width (regfile_addr_width)
    ) i_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_en   (wb_wr_en),
        .wr_addr (wb_addr),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute_pipe #(
        .datapath_width     (datapath_width),
        .regfile_addr_width (regfile_addr_width),
        .inst_addr_width    (inst_addr_width)
    ) i_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .halt          (halt),
        .inst_pc       (inst_pc),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .imm           (imm),
        .shamt         (shamt),
        .branch_offset (branch_offset),
        .alu_op        (alu_op),
        .use_imm       (use_imm),
        .wr_addr       (wr_addr),
        .wr_en         (wr_en),
        .mem_to_reg    (mem_to_reg),
        .mem_write     (mem_write),
        .beq           (beq),
        .bne           (bne),
        .mem_dout_b    (mem_dout_b),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .mem_addr_b    (mem_addr_b),
        .mem_din_b     (mem_din_b),
        .mem_we_b      (mem_we_b),
        .wb_wr_en      (wb_wr_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data)
    );

endmodule

//--- tb/tb_arya.sv
`timescale 1ns/10ps

module tb_arya import arya_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        setup_mem;
    logic        verify_mem;
    logic        enable_mem;
    logic [9:0]  mem_addr;
    logic [63:0] mem_data_in;
    logic [63:0] mem_data_out;

    // program words and data area contents
    logic [31:0] prog [$];
    logic [63:0] data_init [0:511];
    logic [63:0] exp_data [0:511];

    // readback bookkeeping
    logic        rd_req;
    logic        pend_valid = 1'b0;
    logic [9:0]  pend_addr = '0;
    logic [63:0] want;
    int          seed;
    int          steps;
    int          errors = 0;
    int          checks = 0;
    int          expected_checks;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic        waiting_halt = 1'b0;

    arya_top #(
        .datapath_width     (64),
        .mem_addr_width     (10),
        .inst_addr_width    (9),
        .regfile_addr_width (5)
    ) i_arya_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .setup_mem    (setup_mem),
        .verify_mem   (verify_mem),
        .enable_mem   (enable_mem),
        .mem_addr     (mem_addr),
        .mem_data_in  (mem_data_in),
        .mem_data_out (mem_data_out)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // program assembly
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rtype_word(alu_op_t op, int rd, int rs, int rt, int sh);
        return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 2'b00, op};
    endfunction

    function automatic logic [31:0] imm_word(opcode_t op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic void emit(logic [31:0] w);
        prog.push_back(w);
    endfunction

    function automatic void add_nops(int n);
        for (int i = 0; i < n; i++) begin
            emit(32'h0);
        end
    endfunction

    // branch to +8 with three slot markers, one skip marker and one target marker
    function automatic void branch_block(opcode_t op, int rs, int rt, int base);
        emit(imm_word(op, rt, rs, 8));
        for (int k = 0; k < 3; k++) begin
            emit(imm_word(op_sw, 7, 0, base + k));
        end
        // only reached on the fall-through path
        emit(imm_word(op_sw, 8, 0, base + 3));
        add_nops(3);
        emit(imm_word(op_sw, 9, 0, base + 4));
    endfunction

    function automatic void build_program();
        // word 0 is decoded twice right after setup drops
        emit(32'h0);
        // random operands from the preloaded data area
        emit(imm_word(op_lw, 1, 0, 0));
        emit(imm_word(op_lw, 2, 0, 1));
        emit(imm_word(op_lw, 3, 0, 8));
        emit(imm_word(op_addi, 4, 0, 1));
        emit(imm_word(op_addi, 5, 0, 1));
        emit(imm_word(op_addi, 6, 0, 2));
        emit(imm_word(op_ori, 7, 0, 'h1111));
        emit(imm_word(op_ori, 8, 0, 'h2222));
        emit(imm_word(op_ori, 9, 0, 'h3333));
        emit(imm_word(op_addi, 25, 0, 100));
        add_nops(3);
        // every alu op with its own shift amount
        for (int k = 0; k < 9; k++) begin
            emit(rtype_word(alu_op_t'(k), 10 + k, 1, 2, k * 3 + 1));
        end
        emit(rtype_word(alu_slt, 19, 2, 1, 0));
        emit(rtype_word(alu_add, 0, 1, 2, 0));
        add_nops(3);
        for (int k = 0; k < 11; k++) begin
            emit(imm_word(op_sw, (k == 10) ? 0 : 10 + k, 0, 64 + k));
        end
        // sign and zero extension
        emit(imm_word(op_addi, 20, 1, -5));
        emit(imm_word(op_addi, 21, 0, -32768));
        emit(imm_word(op_ori, 22, 0, 'hf0f0));
        emit(imm_word(op_ori, 23, 2, 'h8001));
        add_nops(3);
        for (int k = 0; k < 4; k++) begin
            emit(imm_word(op_sw, 20 + k, 0, 80 + k));
        end
        // load and modify a word, then store it to a computed address
        emit(imm_word(op_addi, 24, 3, 7));
        add_nops(3);
        emit(imm_word(op_sw, 24, 25, 5));
        emit(imm_word(op_sw, 3, 0, 106));
        branch_block(op_beq, 4, 5, 200);
        branch_block(op_beq, 4, 6, 210);
        branch_block(op_bne, 4, 6, 220);
        branch_block(op_bne, 4, 5, 230);
        // store behind halt must never land
        add_nops(3);
        emit(32'hffff_ffff);
        emit(imm_word(op_sw, 7, 0, 120));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [63:0] alu_model(alu_op_t op, logic [63:0] a, logic [63:0] b,
                                              logic [4:0] sh);
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_nor: return ~(a | b);
            alu_slt: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            // shifts take rs only
            alu_sll: return a << sh;
            alu_srl: return a >> sh;
            default: return '0;
        endcase
    endfunction

    // fills exp_data and returns the number of executed instructions
    function automatic int run_reference();
        logic [63:0] regs [0:31];
        logic [31:0] w;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_s;
        logic [8:0]  tgt;
        int          pc;
        int          delay;
        int          n;
        tgt   = '0;
        pc    = 0;
        delay = 0;
        n     = 0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 512; i++) begin
            exp_data[i] = data_init[i];
        end
        while (pc < prog.size() && n < 4096) begin
            w = prog[pc];
            if (w[31:26] == op_halt) begin
                break;
            end
            a     = regs[w[25:21]];
            b     = regs[w[20:16]];
            imm_s = {{48{w[15]}}, w[15:0]};
            case (opcode_t'(w[31:26]))
                op_rtype: regs[w[15:11]] = alu_model(alu_op_t'(w[3:0]), a, b, w[10:6]);
                op_addi:  regs[w[20:16]] = a + imm_s;
                op_ori:   regs[w[20:16]] = a | {48'h0, w[15:0]};
                op_lw:    regs[w[20:16]] = exp_data[9'(a + imm_s)];
                op_sw:    exp_data[9'(a + imm_s)] = b;
                op_beq, op_bne: begin
                    // redirect lands after three executed slots
                    if ((a == b) == (w[31:26] == op_beq)) begin
                        tgt   = 9'(pc + int'(w[8:0]));
                        delay = 4;
                    end
                end
                default: ;
            endcase
            regs[0] = '0;
            n++;
            pc = (pc + 1) % 512;
            if (delay > 0) begin
                delay--;
                if (delay == 0) begin
                    pc = int'(tgt);
                end
            end
        end
        return n;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // debug port access
    //////////////////////////////////////////////////////////////////////

    task automatic write_word(input int addr, input logic [63:0] data);
        @(posedge clk);
        setup_mem   <= 1'b1;
        enable_mem  <= 1'b1;
        mem_addr    <= 10'(addr);
        mem_data_in <= data;
    endtask

    task automatic read_word(input int addr);
        @(posedge clk);
        verify_mem <= 1'b1;
        enable_mem <= 1'b1;
        rd_req     <= 1'b1;
        mem_addr   <= 10'(addr);
    endtask

    task automatic load_memory();
        for (int i = 0; i < 512; i++) begin
            write_word(512 + i, data_init[i]);
        end
        // top down with word 0 last so it sits on port a at start
        for (int i = prog.size() - 1; i >= 0; i--) begin
            write_word(i, {32'h0, prog[i]});
        end
        @(posedge clk);
        setup_mem  <= 1'b0;
        enable_mem <= 1'b0;
    endtask

    // read data lines up with the request one cycle later
    always @(posedge clk) begin
        pend_valid <= rd_req;
        pend_addr  <= mem_addr;
    end

    // compare on the falling edge
    always @(negedge clk) begin
        if (pend_valid) begin
            checks++;
            if (pend_addr < 10'd512) begin
                want = {32'h0, prog[pend_addr]};
            end else begin
                want = exp_data[pend_addr[8:0]];
            end
            if (mem_data_out !== want) begin
                errors++;
                $display("ERR %0t: word %0d read %h, expected %h",
                         $time, pend_addr, mem_data_out, want);
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            if (waiting_halt) begin
                $display("the program never reached its halt instruction");
            end else begin
                $display("run did not finish within %0d cycles", cycle_limit);
            end
            $display("errors: %0d, words compared: %0d", errors, checks);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst_n       <= 1'b0;
        setup_mem   <= 1'b0;
        verify_mem  <= 1'b0;
        enable_mem  <= 1'b0;
        mem_addr    <= '0;
        mem_data_in <= '0;
        rd_req      <= 1'b0;
        seed = 68062;
        for (int i = 0; i < 512; i++) begin
            data_init[i] = {$random(seed), $random(seed)};
        end
        build_program();
        steps           = run_reference();
        expected_checks = prog.size() + 512;
        // load, run and readback cycles doubled plus a margin
        cycle_limit = 2 * ((517 + prog.size()) + (steps + 12) + (expected_checks + 4)) + 100;
        // host owns the memory before reset releases
        @(posedge clk);
        setup_mem  <= 1'b1;
        enable_mem <= 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        load_memory();
        waiting_halt = 1'b1;
        @(negedge clk);
        while (mem_data_out[31:26] != op_halt) begin
            @(negedge clk);
        end
        waiting_halt = 1'b0;
        repeat (4) @(posedge clk);
        for (int i = 0; i < prog.size(); i++) begin
            read_word(i);
        end
        for (int i = 512; i < 1024; i++) begin
            read_word(i);
        end
        // verify stays high so the core stays halted
        @(posedge clk);
        rd_req <= 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: %0d, words compared: %0d", errors, checks);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
src/arya_pkg.sv
src/fetch_unit.sv
src/unified_mem.sv
src/inst_decoder.sv
src/regfile.sv
src/execute_pipe.sv
src/arya_top.sv
tb/tb_arya.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f files.f --top-module tb_arya -o sim_arya
./obj_dir/sim_arya | tee sim.log
if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
